// File: logic/fpu_pkg.sv
/*
  single-precision fpu package
  opcode and rounding encodings, width types and the
  structs passed between the issue, unit and output stages
*/
`default_nettype none

package fpu_pkg;

  //////////////////////////////
  // encodings
  //////////////////////////////

  typedef enum logic [2:0] {
    OP_I2F    = 3'd0, // int32 -> float
    OP_F2I    = 3'd1, // float -> int32
    OP_CMP_EQ = 3'd2,
    OP_CMP_NE = 3'd3,
    OP_CMP_GT = 3'd4,
    OP_CMP_GE = 3'd5,
    OP_CMP_LT = 3'd6,
    OP_CMP_LE = 3'd7
  } fpu_op_e;

  typedef enum logic [1:0] {
    RM_NEAREST_EVEN = 2'd0,
    RM_ZERO         = 2'd1, // truncate
    RM_UP           = 2'd2, // toward +inf
    RM_DOWN         = 2'd3  // toward -inf
  } rmode_e;

  // float -> int policy
  typedef enum logic {
    FTOI_TRUNC = 1'b0, // c style, always toward zero
    FTOI_RMODE = 1'b1  // obeys rmode
  } ftoi_mode_e;

  typedef logic [31:0] word_t;
  typedef logic [9:0]  exp_t;     // restored exponent, spare top bits
  typedef logic [23:0] fract24_t; // hidden bit at [23]

  localparam int FLOAT_BIAS = 127;

  //////////////////////////////
  // stage structs
  //////////////////////////////

  // one unpacked and classified operand
  typedef struct packed {
    logic     sign;
    exp_t     exp;
    fract24_t fract;
    logic     is_zero;
    logic     is_inf;
    logic     is_snan;
    logic     is_qnan;
  } fpu_operand_t;

  // stage 1 register contents
  typedef struct packed {
    fpu_op_e      op;
    rmode_e       rmode;
    word_t        opa_raw; // i2f source
    fpu_operand_t a;
    fpu_operand_t b;
  } fpu_issue_t;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp8;    // biased
    logic [31:0] fract32; // leading one at [31]
    logic        is_zero;
  } i2f_res_t;

  typedef struct packed {
    logic  sign;
    word_t mag;    // truncated magnitude
    logic  guard;
    logic  sticky;
    logic  ovf;
    logic  nan;
  } f2i_res_t;

  typedef struct packed {
    logic flag;
    logic invalid;
  } cmp_res_t;

  typedef struct packed {
    logic invalid;
    logic inexact;
    logic zero;
  } fpu_flags_t;

endpackage

`default_nettype wire

// File: logic/fpu_cmp.sv
/*
  fpu ordered compare
  eq / ne / gt / ge / lt / le on two classified operands,
  with nan handling and the invalid flag
*/
`timescale 1ns/1ps
`default_nettype none

module fpu_cmp (
  input  wire fpu_pkg::fpu_issue_t stage_i,
  output fpu_pkg::cmp_res_t        res_o
);
  import fpu_pkg::*;

  fpu_operand_t a;
  fpu_operand_t b;
  logic         any_nan;
  logic         any_snan;
  logic         both_zero;
  logic         mag_gt;
  logic         mag_eq;
  logic         a_eq_b;
  logic         a_gt_b;
  logic         a_lt_b;
  logic         ordered_op;

  assign a = stage_i.a;
  assign b = stage_i.b;

  assign any_snan  = a.is_snan | b.is_snan;
  assign any_nan   = any_snan | a.is_qnan | b.is_qnan;
  assign both_zero = a.is_zero & b.is_zero; // +0 == -0

  // magnitude order, inf sorts above every finite value
  assign mag_gt = {a.exp, a.fract} > {b.exp, b.fract};
  assign mag_eq = {a.exp, a.fract} == {b.exp, b.fract};

  assign a_eq_b = both_zero | ((a.sign == b.sign) & mag_eq);
  always_comb begin
    if (both_zero) begin
      a_gt_b = 1'b0;
    end else if (a.sign != b.sign) begin
      a_gt_b = ~a.sign;              // positive side wins
    end else begin
      a_gt_b = a.sign ? (~mag_gt & ~mag_eq) : mag_gt; // negatives reversed
    end
  end
  assign a_lt_b = ~a_gt_b & ~a_eq_b;

  // the four relational ops signal on any nan
  assign ordered_op = (stage_i.op == OP_CMP_GT) | (stage_i.op == OP_CMP_GE) |
                      (stage_i.op == OP_CMP_LT) | (stage_i.op == OP_CMP_LE);

  always_comb begin
    res_o.invalid = any_snan | (any_nan & ordered_op);
    case (stage_i.op)
      OP_CMP_EQ: res_o.flag = a_eq_b;
      OP_CMP_NE: res_o.flag = ~a_eq_b;
      OP_CMP_GT: res_o.flag = a_gt_b;
      OP_CMP_GE: res_o.flag = a_gt_b | a_eq_b;
      OP_CMP_LT: res_o.flag = a_lt_b;
      OP_CMP_LE: res_o.flag = a_lt_b | a_eq_b;
      default:   res_o.flag = 1'b0;  // conversions
    endcase
    if (any_nan) begin
      res_o.flag = (stage_i.op == OP_CMP_NE); // unordered
    end
  end

endmodule

`default_nettype wire

// File: logic/fpu_i2f.sv
/*
  fpu int32 to float, normalize half
  abs value, leading zero count and left shift so the
  top bit is one; rounding is done in the output stage
*/
`timescale 1ns/1ps
`default_nettype none

module fpu_i2f (
  input  wire fpu_pkg::fpu_issue_t stage_i,
  output fpu_pkg::i2f_res_t        res_o
);
  import fpu_pkg::*;

  word_t      raw;
  logic       sgn;
  word_t      abs_val;
  logic [4:0] lzc;      // leading zeros of abs_val

  assign raw = stage_i.opa_raw;
  assign sgn = raw[31];

  // two's complement magnitude, 80000000 maps to itself as unsigned
  assign abs_val = sgn ? (~raw + 32'd1) : raw;

  //////////////////////////////
  // leading zero count
  //////////////////////////////

  // highest set bit wins, loop runs upward
  always_comb begin
    lzc = 5'd0;
    for (int i = 0; i < 32; i++) begin
      if (abs_val[i]) begin
        lzc = 5'(31 - i);
      end
    end
  end

  //////////////////////////////
  // normalized result
  //////////////////////////////

  always_comb begin
    res_o.sign    = sgn;
    res_o.exp8    = 8'(FLOAT_BIAS + 31 - int'(lzc)); // 127..158
    res_o.fract32 = abs_val << lzc;                   // msb now set
    res_o.is_zero = ~|raw;
  end

endmodule

`default_nettype wire

// File: logic/fpu_f2i.sv
/*
  fpu float to int32, alignment half
  moves the fraction to the integer point, keeps guard and
  sticky for rounding and flags overflow and nan
*/
`timescale 1ns/1ps
`default_nettype none

module fpu_f2i (
  input  wire fpu_pkg::fpu_issue_t stage_i,
  output fpu_pkg::f2i_res_t        res_o
);
  import fpu_pkg::*;

  fpu_operand_t       a;
  logic signed [10:0] unb_exp;   // exponent without bias
  logic [4:0]         rshift;    // 1..25, clamped
  logic [3:0]         lshift;    // 0..8
  logic [55:0]        window;    // {int part, fraction below point}
  logic               exact_min; // exactly -2^31

  assign a       = stage_i.a;
  assign unb_exp = $signed({1'b0, a.exp}) - 11'(FLOAT_BIAS);

  assign exact_min = a.sign & (unb_exp == 11'sd31) & (a.fract == 24'h800000);

  // right shift distance for the small exponents
  assign rshift = (unb_exp < -11'sd2) ? 5'd25 : 5'(11'sd23 - unb_exp);
  // left shift distance for exp 23..31, larger ones overflow anyway
  assign lshift = (unb_exp > 11'sd31) ? 4'd8 : 4'(unb_exp - 11'sd23);

  assign window = {a.fract, 32'd0} >> rshift;

  //////////////////////////////
  // aligned result
  //////////////////////////////

  always_comb begin
    res_o.sign = a.sign;
    if (unb_exp >= 11'sd23) begin
      res_o.mag    = {8'd0, a.fract} << lshift; // already integral
      res_o.guard  = 1'b0;
      res_o.sticky = 1'b0;
    end else begin
      res_o.mag    = {8'd0, window[55:32]};
      res_o.guard  = window[31];                 // first bit below the point
      res_o.sticky = |window[30:0];
    end
    // int32 holds |x| < 2^31 plus the single value -2^31
    res_o.ovf = a.is_inf | ((unb_exp >= 11'sd31) & ~exact_min);
    res_o.nan = a.is_snan | a.is_qnan;
  end

endmodule

`default_nettype wire

// File: logic/fpu_round_pack.sv
/*
  fpu output stage
  picks the unit result by opcode, rounds and packs i2f,
  rounds/negates/saturates f2i, sets flags and owns the
  stage 2 register, the valids and the pipe advance
*/
`timescale 1ns/1ps
`default_nettype none

module fpu_round_pack #(
  parameter fpu_pkg::ftoi_mode_e ftoi_mode = fpu_pkg::FTOI_TRUNC
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      flush_i,
  input  wire                      adv_i,
  input  wire fpu_pkg::fpu_issue_t stage_i,
  input  wire                      stage_valid_i,
  input  wire fpu_pkg::cmp_res_t   cmp_i,
  input  wire fpu_pkg::i2f_res_t   i2f_i,
  input  wire fpu_pkg::f2i_res_t   f2i_i,
  output logic                     advance_o,
  output fpu_pkg::word_t           result_o,
  output logic                     arith_valid_o,
  output logic                     cmp_flag_o,
  output logic                     cmp_valid_o,
  output fpu_pkg::fpu_flags_t      flags_o
);
  import fpu_pkg::*;

  // one increment decision for both conversions
  function automatic logic round_up(input rmode_e rm, input logic sgn, input logic lsb,
                                    input logic grd, input logic stk);
    logic inc;
    case (rm)
      RM_NEAREST_EVEN: inc = grd & (stk | lsb); // ties go to even
      RM_UP:           inc = ~sgn & (grd | stk);
      RM_DOWN:         inc = sgn & (grd | stk); // grows magnitude when negative
      default:         inc = 1'b0;              // toward zero
    endcase
    return inc;
  endfunction

  logic        i2f_grd;
  logic        i2f_stk;
  logic        i2f_inc;
  logic [24:0] i2f_sum;   // 24 kept bits plus carry
  logic [7:0]  i2f_exp;
  logic [22:0] i2f_man;
  word_t       i2f_word;
  logic        f2i_inc;
  word_t       f2i_mag_r;
  word_t       f2i_val;
  logic        f2i_sat;
  word_t       f2i_word;
  word_t       res_d;
  fpu_flags_t  flags_d;
  logic        is_arith;
  logic        load;

  //////////////////////////////
  // i2f round and pack
  //////////////////////////////

  always_comb begin
    i2f_grd = i2f_i.fract32[7];
    i2f_stk = |i2f_i.fract32[6:0];
    i2f_inc = round_up(stage_i.rmode, i2f_i.sign, i2f_i.fract32[8], i2f_grd, i2f_stk);
    i2f_sum = {1'b0, i2f_i.fract32[31:8]} + 25'(i2f_inc);
    if (i2f_sum[24]) begin
      i2f_exp = i2f_i.exp8 + 8'd1;   // mantissa wrapped to 1.0
      i2f_man = i2f_sum[23:1];
    end else begin
      i2f_exp = i2f_i.exp8;
      i2f_man = i2f_sum[22:0];
    end
    i2f_word = i2f_i.is_zero ? 32'd0 : {i2f_i.sign, i2f_exp, i2f_man};
  end

  //////////////////////////////
  // f2i round, sign, saturate
  //////////////////////////////

  always_comb begin
    if (ftoi_mode == FTOI_RMODE) begin
      f2i_inc = round_up(stage_i.rmode, f2i_i.sign, f2i_i.mag[0], f2i_i.guard, f2i_i.sticky);
    end else begin
      f2i_inc = 1'b0;               // plain truncation
    end
    f2i_mag_r = f2i_i.mag + 32'(f2i_inc); // cannot carry past 2^24 here
    f2i_val   = f2i_i.sign ? (~f2i_mag_r + 32'd1) : f2i_mag_r;
    f2i_sat   = f2i_i.ovf | f2i_i.nan;
    if (f2i_sat) begin
      f2i_word = (f2i_i.nan | ~f2i_i.sign) ? 32'h7fffffff : 32'h80000000;
    end else begin
      f2i_word = f2i_val;
    end
  end

  //////////////////////////////
  // result select and flags
  //////////////////////////////

  assign is_arith = (stage_i.op == OP_I2F) | (stage_i.op == OP_F2I);

  always_comb begin
    res_d   = 32'd0;                // compares return 0
    flags_d = '0;
    case (stage_i.op)
      OP_I2F: begin
        res_d           = i2f_word;
        flags_d.inexact = i2f_grd | i2f_stk;
        flags_d.zero    = i2f_i.is_zero;
      end
      OP_F2I: begin
        res_d           = f2i_word;
        flags_d.invalid = f2i_sat;
        flags_d.inexact = (f2i_i.guard | f2i_i.sticky) & ~f2i_sat;
        flags_d.zero    = ~f2i_sat & (f2i_val == 32'd0);
      end
      default: begin
        flags_d.invalid = cmp_i.invalid;
      end
    endcase
  end

  // move on when consumer takes the result or nothing is held
  assign advance_o = adv_i | ~(arith_valid_o | cmp_valid_o);
  assign load      = advance_o & stage_valid_i;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      arith_valid_o <= 1'b0;
      cmp_valid_o   <= 1'b0;
    end else if (flush_i) begin
      arith_valid_o <= 1'b0;
      cmp_valid_o   <= 1'b0;
    end else if (advance_o) begin
      arith_valid_o <= stage_valid_i & is_arith;
      cmp_valid_o   <= stage_valid_i & ~is_arith;
    end
  end

  // flags read 0 until the first result
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      flags_o    <= '0;
      cmp_flag_o <= 1'b0;
    end else if (load) begin
      flags_o    <= flags_d;
      cmp_flag_o <= ~is_arith & cmp_i.flag;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      result_o <= res_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/fpu_issue.sv
/*
  fpu issue stage
  takes a start, unpacks and classifies both operands
  and registers them with the opcode as stage 1
*/
`timescale 1ns/1ps
`default_nettype none

module fpu_issue (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     flush_i,
  input  wire                     start_i,
  input  wire fpu_pkg::fpu_op_e   op_i,
  input  wire fpu_pkg::rmode_e    rmode_i,
  input  wire fpu_pkg::word_t     opa_i,
  input  wire fpu_pkg::word_t     opb_i,
  input  wire                     advance_i,
  output fpu_pkg::fpu_issue_t     stage_o,
  output logic                    stage_valid_o
);
  import fpu_pkg::*;

  // split one ieee single into sign / restored exp / fract + class bits
  function automatic fpu_operand_t unpack(input word_t w);
    fpu_operand_t o;
    logic [7:0]   e8;
    logic [22:0]  f23;
    logic         exp_ff;
    logic         exp_00;
    logic         denorm;
    e8     = w[30:23];
    f23    = w[22:0];
    exp_ff = &e8;
    exp_00 = ~|e8;
    denorm = exp_00 & (|f23);                   // tiny, no hidden bit
    o.sign    = w[31];
    o.exp     = {2'b00, e8[7:1], e8[0] | denorm}; // denormals act as exp 1
    o.fract   = {~exp_00, f23};                 // hidden bit for normals only
    o.is_zero = exp_00 & ~(|f23);
    o.is_inf  = exp_ff & ~(|f23);
    o.is_snan = exp_ff & ~f23[22] & (|f23[21:0]);
    o.is_qnan = exp_ff & f23[22];
    return o;
  endfunction

  //////////////////////////////
  // stage 1 valid
  //////////////////////////////

  // start is taken only on an advancing edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stage_valid_o <= 1'b0;
    end else if (flush_i) begin
      stage_valid_o <= 1'b0;  // drop the op in flight
    end else if (advance_i) begin
      stage_valid_o <= start_i;
    end
  end

  //////////////////////////////
  // stage 1 payload
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (advance_i) begin
      stage_o.op      <= op_i;
      stage_o.rmode   <= rmode_i;
      stage_o.opa_raw <= opa_i;          // int source for i2f
      stage_o.a       <= unpack(opa_i);
      stage_o.b       <= unpack(opb_i);
    end
  end

endmodule

`default_nettype wire

// File: logic/fpu_top.sv
/*
  single-precision fpu top
  issue stage, compare and conversion units and the
  rounding output stage, two edges from start to result
*/
`timescale 1ns/1ps
`default_nettype none

module fpu_top #(
  parameter fpu_pkg::ftoi_mode_e ftoi_mode = fpu_pkg::FTOI_TRUNC
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     flush_i,
  input  wire                     start_i,
  input  wire fpu_pkg::fpu_op_e   op_i,
  input  wire fpu_pkg::rmode_e    rmode_i,
  input  wire fpu_pkg::word_t     opa_i,
  input  wire fpu_pkg::word_t     opb_i,
  input  wire                     adv_i,
  output logic                    ready_o,  // also the pipe advance
  output fpu_pkg::word_t          result_o,
  output logic                    arith_valid_o,
  output logic                    cmp_flag_o,
  output logic                    cmp_valid_o,
  output fpu_pkg::fpu_flags_t     flags_o
);
  import fpu_pkg::*;

  fpu_issue_t stage;        // stage 1 register
  logic       stage_valid;
  cmp_res_t   cmp_res;
  i2f_res_t   i2f_res;
  f2i_res_t   f2i_res;

  //////////////////////////////
  // stage 1
  //////////////////////////////

  fpu_issue u_issue (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .start_i       (start_i),
    .op_i          (op_i),
    .rmode_i       (rmode_i),
    .opa_i         (opa_i),
    .opb_i         (opb_i),
    .advance_i     (ready_o),
    .stage_o       (stage),
    .stage_valid_o (stage_valid)
  );

  // combinational units between the stages
  fpu_cmp u_cmp (.stage_i(stage), .res_o(cmp_res));
  fpu_i2f u_i2f (.stage_i(stage), .res_o(i2f_res));
  fpu_f2i u_f2i (.stage_i(stage), .res_o(f2i_res));

  //////////////////////////////
  // stage 2
  //////////////////////////////

  fpu_round_pack #(
    .ftoi_mode (ftoi_mode)
  ) u_round_pack (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .adv_i         (adv_i),
    .stage_i       (stage),
    .stage_valid_i (stage_valid),
    .cmp_i         (cmp_res),
    .i2f_i         (i2f_res),
    .f2i_i         (f2i_res),
    .advance_o     (ready_o),
    .result_o      (result_o),
    .arith_valid_o (arith_valid_o),
    .cmp_flag_o    (cmp_flag_o),
    .cmp_valid_o   (cmp_valid_o),
    .flags_o       (flags_o)
  );

endmodule

`default_nettype wire

// File: dv/fpu_tb.sv
/*
  fpu directed testbench
  compare, int/float conversions, back-to-back issue,
  back-pressure and flush, checked against reference models
*/
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;
  import fpu_pkg::*;

  localparam int TIMEOUT = 50; // edges per wait

  logic       clk;
  logic       rst;
  logic       flush_i;
  logic       start_i;
  fpu_op_e    op_i;
  rmode_e     rmode_i;
  word_t      opa_i;
  word_t      opb_i;
  logic       adv_i;
  logic       ready_o;
  word_t      result_o;
  logic       arith_valid_o;
  logic       cmp_flag_o;
  logic       cmp_valid_o;
  fpu_flags_t flags_o;

  int    errors;
  int    checks;
  word_t lfsr_state;

  fpu_top #(.ftoi_mode(FTOI_RMODE)) fpu_top_inst (
    .clk(clk), .rst(rst), .flush_i(flush_i), .start_i(start_i), .op_i(op_i),
    .rmode_i(rmode_i), .opa_i(opa_i), .opb_i(opb_i), .adv_i(adv_i), .ready_o(ready_o),
    .result_o(result_o), .arith_valid_o(arith_valid_o), .cmp_flag_o(cmp_flag_o),
    .cmp_valid_o(cmp_valid_o), .flags_o(flags_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic word_t rand_word();
    word_t w;
    logic  fb;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      w          = {w[30:0], fb};
    end
    return w;
  endfunction

  task automatic to_drive_point();
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_word(input string what, input word_t got, input word_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_flags(input string what, input fpu_flags_t got, input fpu_flags_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  //////////////////////////////
  // reference models
  //////////////////////////////

  // ieee ordering on sign-magnitude keys, nan is unordered
  function automatic cmp_res_t cmp_model(input fpu_op_e op, input word_t a, input word_t b);
    cmp_res_t r;
    logic     a_nan, b_nan, any_snan;
    longint   ka, kb;
    a_nan    = (a[30:23] == 8'hff) && (a[22:0] != 0);
    b_nan    = (b[30:23] == 8'hff) && (b[22:0] != 0);
    any_snan = (a_nan && !a[22]) || (b_nan && !b[22]);
    ka = {33'd0, a[30:0]};
    kb = {33'd0, b[30:0]};
    if (a[31]) ka = -ka;  // -0 folds onto +0
    if (b[31]) kb = -kb;
    r.invalid = any_snan || ((a_nan || b_nan) && op >= OP_CMP_GT);
    case (op)
      OP_CMP_EQ: r.flag = (ka == kb);
      OP_CMP_NE: r.flag = (ka != kb);
      OP_CMP_GT: r.flag = (ka > kb);
      OP_CMP_GE: r.flag = (ka >= kb);
      OP_CMP_LT: r.flag = (ka < kb);
      default:   r.flag = (ka <= kb);
    endcase
    if (a_nan || b_nan) r.flag = (op == OP_CMP_NE);
    return r;
  endfunction

  // increment rule shared by both conversions
  function automatic logic rounds_up(input rmode_e rm, input logic sgn, input logic odd,
                                     input logic gt_half, input logic eq_half, input logic nz);
    case (rm)
      RM_NEAREST_EVEN: return gt_half || (eq_half && odd);
      RM_UP:           return !sgn && nz;
      RM_DOWN:         return sgn && nz;
      default:         return 1'b0;
    endcase
  endfunction

  function automatic word_t i2f_model(input word_t x, input rmode_e rm, output fpu_flags_t fl);
    logic   sgn;
    longint mag, kept, rem, half;
    int     p, sh;
    fl = '0;
    if (x == 0) begin
      fl.zero = 1'b1;
      return 32'd0;
    end
    sgn = x[31];
    mag = {32'd0, x};
    if (sgn) mag = 64'h1_0000_0000 - mag;
    p = 0;
    for (int i = 0; i < 32; i++) if (mag[i]) p = i; // msb position
    sh   = (p > 23) ? p - 23 : 0;
    kept = (p > 23) ? (mag >> sh) : (mag << (23 - p));
    rem  = (p > 23) ? (mag & ((64'd1 << sh) - 1)) : 0;
    half = (p > 23) ? (64'd1 << (sh - 1)) : 1;
    kept = kept + rounds_up(rm, sgn, kept[0], rem > half, rem == half, rem != 0);
    if (kept == (64'd1 << 24)) begin
      kept = kept >> 1; // carried into a new binade
      p++;
    end
    fl.inexact = (rem != 0);
    return {sgn, 8'(FLOAT_BIAS + p), kept[22:0]};
  endfunction

  function automatic word_t f2i_model(input word_t f, input rmode_e rm, output fpu_flags_t fl);
    logic   sgn, nz, gt_half, eq_half;
    int     e, sh;
    longint mant, ip, rem, half, lim;
    word_t  res;
    fl  = '0;
    sgn = f[31];
    if (f[30:23] == 8'hff) begin
      fl.invalid = 1'b1;
      return (f[22:0] != 0 || !sgn) ? 32'h7fffffff : 32'h80000000;
    end
    mant = (f[30:23] == 0) ? {41'd0, f[22:0]} : {40'd0, 1'b1, f[22:0]};
    e    = (f[30:23] == 0) ? -126 : int'(f[30:23]) - 127;
    nz = 1'b0;
    gt_half = 1'b0;
    eq_half = 1'b0;
    if (e > 31) begin
      ip = 64'h1_0000_0000;         // far out of range
    end else if (e >= 23) begin
      ip = mant << (e - 23);
    end else begin
      sh = 23 - e;
      if (sh > 40) begin
        ip = 0;
        nz = (mant != 0);
      end else begin
        ip      = mant >> sh;
        rem     = mant & ((64'd1 << sh) - 1);
        half    = 64'd1 << (sh - 1);
        nz      = (rem != 0);
        gt_half = (rem > half);
        eq_half = (rem == half);
      end
    end
    ip  = ip + rounds_up(rm, sgn, ip[0], gt_half, eq_half, nz);
    lim = sgn ? 64'h8000_0000 : 64'h7fff_ffff;
    if (ip > lim) begin
      fl.invalid = 1'b1;
      return sgn ? 32'h80000000 : 32'h7fffffff;
    end
    res = ip[31:0];
    if (sgn) res = ~res + 32'd1;
    fl.inexact = nz;
    fl.zero    = (res == 0);
    return res;
  endfunction

  //////////////////////////////
  // drive and wait
  //////////////////////////////

  // holds the start until an edge with ready high
  task automatic issue(input fpu_op_e op, input rmode_e rm, input word_t a, input word_t b,
                       output logic ok);
    int n;
    to_drive_point();
    start_i = 1'b1;
    op_i    = op;
    rmode_i = rm;
    opa_i   = a;
    opb_i   = b;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < TIMEOUT) begin
      @(negedge clk);
      ok = ready_o;
      to_drive_point();
      n++;
    end
    start_i = 1'b0;
    if (!ok) begin
      errors++;
      $display("timeout: start not accepted within %0d cycles", TIMEOUT);
    end
  endtask

  // counts edges until a valid shows, sampled at the falling edge
  task automatic wait_result(output int edges, output logic got);
    got   = 1'b0;
    edges = 0;
    while (!got && edges < TIMEOUT) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      got = arith_valid_o | cmp_valid_o;
    end
    if (!got) begin
      errors++;
      $display("timeout: no result valid within %0d edges", TIMEOUT);
    end
  endtask

  task automatic run_op(input fpu_op_e op, input rmode_e rm, input word_t a, input word_t b,
                        output word_t res, output fpu_flags_t fl, output logic cflag,
                        output logic av, output logic cv, output int edges);
    logic ok;
    logic got;
    edges = 0;
    issue(op, rm, a, b, ok);
    if (ok) begin
      wait_result(edges, got);
      edges++;                   // the accepting edge is edge one
    end
    res   = result_o;
    fl    = flags_o;
    cflag = cmp_flag_o;
    av    = arith_valid_o;
    cv    = cmp_valid_o;
  endtask

  // two i2f-first starts on consecutive edges
  task automatic issue_pair(input word_t a1, input fpu_op_e op2, input word_t a2);
    logic r0, r1;
    to_drive_point();
    start_i = 1'b1;
    op_i    = OP_I2F;
    rmode_i = RM_NEAREST_EVEN;
    opa_i   = a1;
    opb_i   = '0;
    @(negedge clk);
    r0 = ready_o;
    to_drive_point();
    op_i  = op2;
    opa_i = a2;
    @(negedge clk);
    r1 = ready_o;
    to_drive_point();
    start_i = 1'b0;
    check_bit("first start accepted", r0, 1'b1);
    check_bit("second start accepted", r1, 1'b1);
  endtask

  task automatic conv_case(input fpu_op_e op, input rmode_e rm, input word_t x);
    word_t      res, want;
    fpu_flags_t fl, fl_want;
    logic       cflag, av, cv;
    int         edges;
    string      tag;
    run_op(op, rm, x, 32'd0, res, fl, cflag, av, cv, edges);
    if (op == OP_I2F) want = i2f_model(x, rm, fl_want);
    else want = f2i_model(x, rm, fl_want);
    tag = $sformatf("%s %s %h", op.name(), rm.name(), x);
    check_word({tag, " result"}, res, want);
    check_flags({tag, " flags"}, fl, fl_want);
    check_bit({tag, " arith valid"}, av, 1'b1);
    check_bit({tag, " cmp valid"}, cv, 1'b0);
  endtask

  task automatic end_test(input string name, input int err0, input int chk0);
    $display("test %-14s checks %0d errors %0d", name, checks - chk0, errors - err0);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic compare_sweep();
    word_t      pa[$], pb[$];
    word_t      spec_a [8] = '{32'h0, 32'h7f800000, 32'h7f800000, 32'h3f800000,
                               32'h7fa00000, 32'hffc00000, 32'hbf800000, 32'h7fc00000};
    word_t      spec_b [8] = '{32'h80000000, 32'hff800000, 32'h7f800000, 32'h7fc00000,
                               32'h3f800000, 32'hff800000, 32'h3f800000, 32'h7f800001};
    word_t      w, res;
    fpu_flags_t fl, fl_want;
    logic       cflag, av, cv;
    int         edges, err0, chk0;
    cmp_res_t   want;
    fpu_op_e    op;
    string      tag;
    err0 = errors;
    chk0 = checks;
    for (int i = 0; i < 40; i++) begin
      pa.push_back(rand_word());
      pb.push_back(rand_word());
    end
    foreach (spec_a[i]) begin
      pa.push_back(spec_a[i]);
      pb.push_back(spec_b[i]);
    end
    w = rand_word();
    pa.push_back(w);          // equal pair
    pb.push_back(w);
    pa.push_back(w);          // opposite signs
    pb.push_back(w ^ 32'h80000000);
    foreach (pa[i]) begin
      for (int k = 2; k < 8; k++) begin
        op = fpu_op_e'(k);
        run_op(op, RM_NEAREST_EVEN, pa[i], pb[i], res, fl, cflag, av, cv, edges);
        want    = cmp_model(op, pa[i], pb[i]);
        fl_want = '0;
        fl_want.invalid = want.invalid;
        tag = $sformatf("%s %h %h", op.name(), pa[i], pb[i]);
        check_bit({tag, " flag"}, cflag, want.flag);
        check_flags({tag, " flags"}, fl, fl_want);
        check_word({tag, " result"}, res, 32'd0);
        check_bit({tag, " cmp valid"}, cv, 1'b1);
        check_bit({tag, " arith valid"}, av, 1'b0);
        check_bit({tag, " two-edge latency"}, edges == 2, 1'b1);
      end
    end
    end_test("compare", err0, chk0);
  endtask

  task automatic i2f_sweep();
    word_t ins[$];
    word_t fixed_in [6] = '{32'h0, 32'h1, 32'hffffffff, 32'h01000001, 32'h7fffffff,
                            32'h80000000};
    int    err0, chk0;
    err0 = errors;
    chk0 = checks;
    foreach (fixed_in[i]) ins.push_back(fixed_in[i]);
    for (int i = 0; i < 30; i++) ins.push_back($signed(rand_word()) >>> (i % 24));
    foreach (ins[i]) begin
      for (int m = 0; m < 4; m++) conv_case(OP_I2F, rmode_e'(m), ins[i]);
    end
    end_test("int to float", err0, chk0);
  endtask

  task automatic f2i_sweep();
    // 1.5 2.5 -2.5 0.3 -0.3 0.5, near 2^31, inf, nan, zeros, denormal
    word_t ins [17] = '{32'h3fc00000, 32'h40200000, 32'hc0200000, 32'h3e99999a, 32'hbe99999a,
                        32'h3f000000, 32'h4effffff, 32'h4f000000, 32'hcf000000, 32'hcf000001,
                        32'h7f800000, 32'hff800000, 32'h7fc00000, 32'h7f800001, 32'hffc00000,
                        32'h80000000, 32'h00000001};
    int    err0, chk0;
    err0 = errors;
    chk0 = checks;
    foreach (ins[i]) begin
      for (int m = 0; m < 4; m++) conv_case(OP_F2I, rmode_e'(m), ins[i]);
    end
    end_test("float to int", err0, chk0);
  endtask

  task automatic back_to_back_issue();
    word_t      res [2];
    int         at [2];
    int         n, got, err0, chk0;
    fpu_flags_t fl;
    err0 = errors;
    chk0 = checks;
    issue_pair(32'd5, OP_I2F, -32'sd7);
    n   = 0;
    got = 0;
    while (got < 2 && n < TIMEOUT) begin
      @(negedge clk);
      if (arith_valid_o) begin
        res[got] = result_o;
        at[got]  = n;
        got++;
      end
      @(posedge clk);
      n++;
    end
    if (got < 2) begin
      errors++;
      $display("timeout: back-to-back results missing, %0d of 2 seen", got);
    end else begin
      check_word("first result", res[0], i2f_model(32'd5, RM_NEAREST_EVEN, fl));
      check_word("second result", res[1], i2f_model(-32'sd7, RM_NEAREST_EVEN, fl));
      check_bit("results on consecutive cycles", at[1] == at[0] + 1, 1'b1);
    end
    end_test("back to back", err0, chk0);
  endtask

  task automatic backpressure_hold();
    word_t      want_a, want_b;
    fpu_flags_t fl;
    int         err0, chk0;
    err0 = errors;
    chk0 = checks;
    want_a = i2f_model(32'd3, RM_NEAREST_EVEN, fl);
    want_b = f2i_model(32'h3fc00000, RM_NEAREST_EVEN, fl);
    to_drive_point();
    adv_i = 1'b0;                // consumer stalls
    issue_pair(32'd3, OP_F2I, 32'h3fc00000);
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      check_bit("held valid", arith_valid_o, 1'b1);
      check_word("held result", result_o, want_a);
      check_bit("ready while held", ready_o, 1'b0);
      to_drive_point();
    end
    adv_i = 1'b1;
    @(posedge clk);              // first result taken, second moves up
    @(negedge clk);
    check_bit("second valid after release", arith_valid_o, 1'b1);
    check_word("second result after release", result_o, want_b);
    @(posedge clk);
    @(negedge clk);
    check_bit("valid drops after second result", arith_valid_o, 1'b0);
    end_test("back-pressure", err0, chk0);
  endtask

  task automatic flush_in_flight();
    word_t      res;
    fpu_flags_t fl, fl_want;
    logic       cflag, av, cv, ok, seen;
    int         edges, err0, chk0;
    err0 = errors;
    chk0 = checks;
    issue(OP_I2F, RM_NEAREST_EVEN, 32'd9, 32'd0, ok);
    flush_i = 1'b1;              // op sits in stage 1
    to_drive_point();
    flush_i = 1'b0;
    seen = 1'b0;
    repeat (4) begin
      @(negedge clk);
      seen = seen | arith_valid_o | cmp_valid_o;
      @(posedge clk);
    end
    check_bit("valid after flush", seen, 1'b0);
    run_op(OP_I2F, RM_NEAREST_EVEN, 32'd11, 32'd0, res, fl, cflag, av, cv, edges);
    check_word("op after flush", res, i2f_model(32'd11, RM_NEAREST_EVEN, fl_want));
    check_flags("op after flush flags", fl, fl_want);
    check_bit("op after flush valid", av, 1'b1);
    end_test("flush", err0, chk0);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    rst        = 1'b1;
    flush_i    = 1'b0;
    start_i    = 1'b0;
    op_i       = OP_I2F;
    rmode_i    = RM_NEAREST_EVEN;
    opa_i      = '0;
    opb_i      = '0;
    adv_i      = 1'b1;
    errors     = 0;
    checks     = 0;
    lfsr_state = 32'h49192d8e;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_bit("ready after reset", ready_o, 1'b1);
    check_bit("arith valid after reset", arith_valid_o, 1'b0);
    check_bit("cmp valid after reset", cmp_valid_o, 1'b0);
    check_flags("flags after reset", flags_o, '0);
    compare_sweep();
    i2f_sweep();
    f2i_sweep();
    back_to_back_issue();
    backpressure_hold();
    flush_in_flight();
    $display("total checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
logic/fpu_pkg.sv
logic/fpu_cmp.sv
logic/fpu_i2f.sv
logic/fpu_f2i.sv
logic/fpu_round_pack.sv
logic/fpu_issue.sv
logic/fpu_top.sv
dv/fpu_tb.sv

// File: Bender.yml
package:
  name: fpu

sources:
  - logic/fpu_pkg.sv
  - logic/fpu_cmp.sv
  - logic/fpu_i2f.sv
  - logic/fpu_f2i.sv
  - logic/fpu_round_pack.sv
  - logic/fpu_issue.sv
  - logic/fpu_top.sv
  - target: test
    files:
      - dv/fpu_tb.sv
